// File: logic/board_config.svh
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Pixel entries in the ingress FIFO, also the credits the core owns after reset
`define PIXEL_FIFO_DEPTH 8

`define STATUS_WIDTH 32

// Command byte that opens a status write on the serial link
`define STATUS_CMD 8'h1e

`define CORE_COLOR_W 4
`define VGA_COLOR_W 6

`endif

// File: logic/video_pkg.sv
package video_pkg;

`include "board_config.svh"

	typedef logic [`CORE_COLOR_W-1:0] core_color_t; // One channel as the core drives it
	typedef logic [`VGA_COLOR_W-1:0]  vga_color_t;

	// Scanline effect from status bits 4:3, the HQ2x code 1 is folded into SL_NONE
	typedef enum logic [1:0] {
		SL_NONE = 2'd0,
		SL_25   = 2'd2,
		SL_50   = 2'd3
	} scanline_mode_t;

endpackage

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

`include "board_config.svh"

	typedef logic [`STATUS_WIDTH-1:0] status_t; // Option bits from the board controller
	typedef logic [7:0]               spi_byte_t;

	// Receiver progress through one frame
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_CMD,
		RX_STATUS,
		RX_IGNORE
	} spi_state_t;

endpackage

// File: logic/status_spi_rx.sv
`timescale 1ns/100ps
`include "board_config.svh"

module status_spi_rx (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      spi_sck,
	input  logic                      spi_ss_n,
	input  logic                      spi_di,
	input  logic [1:0]                buttons,
	output ctrl_pkg::status_t         status,
	output video_pkg::scanline_mode_t scanline_mode,
	output logic                      core_reset_n
);
	import ctrl_pkg::*;
	import video_pkg::*;

	logic [2:0] sck_q; // Two sync stages plus one for edge detection
	logic [2:0] ss_q;
	logic [1:0] di_q;
	logic       sck_rise;
	logic       ss_rise;
	logic       selected;
	logic       byte_done;
	logic [3:0] bit_cnt;
	logic [2:0] byte_cnt;
	spi_state_t state;
	spi_byte_t  rx_byte;
	spi_byte_t  byte_in;
	status_t    shadow;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sck_q <= '0;
			ss_q  <= '1;
			di_q  <= '0;
		end else begin
			sck_q <= {sck_q[1:0], spi_sck};
			ss_q  <= {ss_q[1:0], spi_ss_n};
			di_q  <= {di_q[0], spi_di};
		end
	end

	assign sck_rise  = sck_q[1] & ~sck_q[2];
	assign ss_rise   = ss_q[1] & ~ss_q[2]; // End of frame
	assign selected  = ~ss_q[1];
	assign byte_in   = {rx_byte[6:0], di_q[1]}; // MSB first
	assign byte_done = selected && sck_rise && bit_cnt == 4'd7;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state    <= RX_IDLE;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			status   <= '0;
		end else if (!selected) begin
			// Only a frame that delivered all four status bytes gets committed
			if (ss_rise && state == RX_IGNORE && byte_cnt == 3'd4)
				status <= shadow;
			state    <= RX_IDLE;
			bit_cnt  <= '0;
			byte_cnt <= '0;
		end else begin
			if (state == RX_IDLE)
				state <= RX_CMD;
			if (sck_rise)
				bit_cnt <= (bit_cnt == 4'd7) ? 4'd0 : bit_cnt + 4'd1;
			if (byte_done) begin
				case (state)
					RX_IDLE, RX_CMD: begin
						state <= (byte_in == `STATUS_CMD) ? RX_STATUS : RX_IGNORE;
					end
					RX_STATUS: begin
						byte_cnt <= byte_cnt + 3'd1;
						if (byte_cnt == 3'd3)
							state <= RX_IGNORE; // Extra bytes are dropped
					end
					default: state <= RX_IGNORE;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (selected && sck_rise)
			rx_byte <= byte_in;
		if (byte_done && state == RX_STATUS)
			shadow[{byte_cnt[1:0], 3'b000} +: 8] <= byte_in; // Least significant byte first
	end

	assign scanline_mode = (status[4:3] == 2'd1) ? SL_NONE : scanline_mode_t'(status[4:3]);
	assign core_reset_n  = ~(status[0] | status[6] | buttons[1]);

	a_bit_cnt_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
		bit_cnt <= 4'd7);

endmodule

// File: logic/pixel_ingress.sv
`timescale 1ns/100ps
`include "board_config.svh"

module pixel_ingress (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   pix_valid,
	input  video_pkg::core_color_t pix_r,
	input  video_pkg::core_color_t pix_g,
	input  video_pkg::core_color_t pix_b,
	input  logic                   pix_hs,
	input  logic                   pix_vs,
	input  logic                   ce_pix,
	output logic                   credit_return,
	output logic                   head_valid,
	output video_pkg::core_color_t head_r,
	output video_pkg::core_color_t head_g,
	output video_pkg::core_color_t head_b,
	output logic                   head_hs,
	output logic                   head_vs
);
	import video_pkg::*;

	localparam int DEPTH   = `PIXEL_FIFO_DEPTH;
	localparam int PTR_W   = $clog2(DEPTH);
	localparam int ENTRY_W = 3 * $bits(core_color_t) + 2; // Three channels plus both syncs

	logic [ENTRY_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W:0]     count;
	logic               full;
	logic               push;
	logic               pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
	endfunction

	assign full       = count == (PTR_W + 1)'(DEPTH);
	assign head_valid = count != '0;
	assign push       = pix_valid && !full;
	assign pop        = ce_pix && head_valid; // One entry leaves per pixel slot

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + (PTR_W + 1)'(1);
			else if (pop && !push)
				count <= count - (PTR_W + 1)'(1);
			credit_return <= pop; // The freed slot goes back to the core
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= {pix_r, pix_g, pix_b, pix_hs, pix_vs};
	end

	assign {head_r, head_g, head_b, head_hs, head_vs} = mem[rd_ptr];

	// A core that respects its credits never pushes into a full buffer
	a_no_push_when_full: assert property (@(posedge clk_sys) disable iff (!arst_n)
		pix_valid |-> !full);

endmodule

// File: logic/scanline_mixer.sv
`timescale 1ns/100ps
`include "board_config.svh"

module scanline_mixer (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      ce_pix,
	input  video_pkg::scanline_mode_t scanline_mode,
	input  logic                      in_valid,
	input  video_pkg::core_color_t    in_r,
	input  video_pkg::core_color_t    in_g,
	input  video_pkg::core_color_t    in_b,
	input  logic                      in_hs,
	input  logic                      in_vs,
	output logic                      mix_de,
	output video_pkg::vga_color_t     mix_r,
	output video_pkg::vga_color_t     mix_g,
	output video_pkg::vga_color_t     mix_b,
	output logic                      mix_hs,
	output logic                      mix_vs
);
	import video_pkg::*;

	localparam int EXT_W = `VGA_COLOR_W - `CORE_COLOR_W;

	logic take;
	logic line_odd;
	logic line_odd_next;

	// Low bits are repeated so full scale stays full scale
	function automatic vga_color_t widen(input core_color_t c);
		widen = {c, c[EXT_W-1:0]};
	endfunction

	function automatic vga_color_t dim(input vga_color_t c, input scanline_mode_t m,
			input logic odd);
		dim = c;
		if (odd) begin
			case (m)
				SL_25:   dim = c - (c >> 2);
				SL_50:   dim = c >> 1;
				default: dim = c;
			endcase
		end
	endfunction

	assign take = ce_pix && in_valid;

	// mix_hs and mix_vs hold the sync bits of the previous pixel
	always_comb begin
		line_odd_next = line_odd;
		if (in_vs && !mix_vs)
			line_odd_next = 1'b0; // New frame starts on an even line
		else if (in_hs && !mix_hs)
			line_odd_next = ~line_odd;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			line_odd <= 1'b0;
			mix_de   <= 1'b0;
			mix_hs   <= 1'b0;
			mix_vs   <= 1'b0;
		end else if (ce_pix) begin
			mix_de <= in_valid;
			if (in_valid) begin
				line_odd <= line_odd_next;
				mix_hs   <= in_hs;
				mix_vs   <= in_vs;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			mix_r <= dim(widen(in_r), scanline_mode, line_odd_next);
			mix_g <= dim(widen(in_g), scanline_mode, line_odd_next);
			mix_b <= dim(widen(in_b), scanline_mode, line_odd_next);
		end
	end

endmodule

// File: logic/vga_egress.sv
`timescale 1ns/100ps

module vga_egress (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  ce_pix,
	input  logic                  mix_de,
	input  video_pkg::vga_color_t mix_r,
	input  video_pkg::vga_color_t mix_g,
	input  video_pkg::vga_color_t mix_b,
	input  logic                  mix_hs,
	input  logic                  mix_vs,
	output video_pkg::vga_color_t vga_r,
	output video_pkg::vga_color_t vga_g,
	output video_pkg::vga_color_t vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  vga_de,
	output logic                  underflow
);
	logic seen_pixel; // Underflow only counts once the stream has started

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vga_r      <= '0;
			vga_g      <= '0;
			vga_b      <= '0;
			vga_hs     <= 1'b0;
			vga_vs     <= 1'b0;
			vga_de     <= 1'b0;
			seen_pixel <= 1'b0;
			underflow  <= 1'b0;
		end else if (ce_pix) begin
			vga_de <= mix_de;
			if (mix_de) begin
				vga_r      <= mix_r;
				vga_g      <= mix_g;
				vga_b      <= mix_b;
				vga_hs     <= mix_hs;
				vga_vs     <= mix_vs;
				seen_pixel <= 1'b1;
			end else begin
				// Black with the sync levels left where they were
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
				if (seen_pixel)
					underflow <= 1'b1;
			end
		end
	end

endmodule

// File: logic/video_mist_top.sv
`timescale 1ns/100ps

module video_mist_top (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      ce_pix,
	input  logic                      pix_valid,
	input  video_pkg::core_color_t    pix_r,
	input  video_pkg::core_color_t    pix_g,
	input  video_pkg::core_color_t    pix_b,
	input  logic                      pix_hs,
	input  logic                      pix_vs,
	output logic                      credit_return,
	input  logic                      spi_sck,
	input  logic                      spi_ss_n,
	input  logic                      spi_di,
	input  logic [1:0]                buttons,
	output ctrl_pkg::status_t         status,
	output logic                      core_reset_n,
	output video_pkg::vga_color_t     vga_r,
	output video_pkg::vga_color_t     vga_g,
	output video_pkg::vga_color_t     vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs,
	output logic                      vga_de,
	output logic                      underflow
);
	import video_pkg::*;

	scanline_mode_t scanline_mode;
	logic           head_valid;
	core_color_t    head_r;
	core_color_t    head_g;
	core_color_t    head_b;
	logic           head_hs;
	logic           head_vs;
	logic           mix_de;
	vga_color_t     mix_r;
	vga_color_t     mix_g;
	vga_color_t     mix_b;
	logic           mix_hs;
	logic           mix_vs;

	status_spi_rx status_spi_rx (.*);

	pixel_ingress pixel_ingress (.*);

	scanline_mixer scanline_mixer (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.ce_pix        (ce_pix),
		.scanline_mode (scanline_mode),
		.in_valid      (head_valid),
		.in_r          (head_r),
		.in_g          (head_g),
		.in_b          (head_b),
		.in_hs         (head_hs),
		.in_vs         (head_vs),
		.mix_de        (mix_de),
		.mix_r         (mix_r),
		.mix_g         (mix_g),
		.mix_b         (mix_b),
		.mix_hs        (mix_hs),
		.mix_vs        (mix_vs)
	);

	vga_egress vga_egress (.*);

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 10,
	parameter int RESET_CYCLES   = 4
) (
	output logic clk,
	output logic arst_n
);
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Reset releases just after a rising edge so nothing races the clock
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 arst_n = 1'b1;
	end

endmodule

// File: verif/video_mist_tb.sv
`timescale 1ns/100ps
`include "board_config.svh"

module video_mist_tb;
	localparam int DEPTH       = `PIXEL_FIFO_DEPTH;
	localparam int N_PIX       = 40;
	localparam int N_FRAMES    = 6;
	localparam int TOTAL_PIX   = 3 * N_PIX + DEPTH;
	localparam int PIX_NS      = 4 * 20; // One ce_pix every fourth clock
	localparam int FRAME_NS    = (5 * 8 * 8 + 40) * 20;
	localparam int WATCHDOG_NS = 2 * (TOTAL_PIX * PIX_NS + N_FRAMES * FRAME_NS) + 1000;
	localparam int DRAIN_LIMIT = (N_PIX + DEPTH) * 16;

	logic        clk_sys;
	logic        arst_n;
	logic        ce_pix;
	logic        pix_valid;
	logic [3:0]  pix_r;
	logic [3:0]  pix_g;
	logic [3:0]  pix_b;
	logic        pix_hs;
	logic        pix_vs;
	logic        credit_return;
	logic        spi_sck;
	logic        spi_ss_n;
	logic        spi_di;
	logic [1:0]  buttons;
	logic [31:0] status;
	logic        core_reset_n;
	logic [5:0]  vga_r;
	logic [5:0]  vga_g;
	logic [5:0]  vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        vga_de;
	logic        underflow;

	logic [13:0] sent_q[$]; // {r, g, b, hs, vs} in send order
	int          req_count    = 0;
	int          sent_count   = 0;
	int          credits      = DEPTH;
	int          credits_back = 0;
	int          shown        = 0;
	int          ce_phase     = 0;
	int          checks       = 0;
	int          errors       = 0;
	logic        gap_en       = 1'b1;
	logic [1:0]  exp_mode     = 2'd0;
	logic [31:0] exp_status   = 32'd0;

	tb_clock_gen clock_gen (
		.clk    (clk_sys),
		.arst_n (arst_n)
	);

	video_mist_top uut (.*);

	// Odd lines lose a quarter in mode 2 and half in mode 3
	function automatic logic [5:0] expect_color(input logic [3:0] c, input logic [1:0] mode,
			input logic odd);
		logic [5:0] full_scale;
		full_scale   = {c, c[1:0]};
		expect_color = full_scale;
		if (odd) begin
			case (mode)
				2'd2:    expect_color = full_scale - full_scale / 6'd4;
				2'd3:    expect_color = full_scale / 6'd2;
				default: expect_color = full_scale;
			endcase
		end
	endfunction

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic clocks(input int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	task automatic send_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_di  = b[i];
			spi_sck = 1'b0;
			clocks(4);
			spi_sck = 1'b1; // Receiver samples on this edge
			clocks(4);
		end
	endtask

	task automatic status_frame(input logic [7:0] cmd, input logic [31:0] word, input int nbytes);
		spi_ss_n = 1'b0;
		clocks(4);
		send_byte(cmd);
		for (int i = 0; i < nbytes; i++)
			send_byte(word[8*i +: 8]);
		spi_sck = 1'b0;
		clocks(4);
		spi_ss_n = 1'b1;
		clocks(8);
		if (cmd == `STATUS_CMD && nbytes >= 4)
			exp_status = word;
		exp_mode = (exp_status[4:3] == 2'd1) ? 2'd0 : exp_status[4:3];
	endtask

	task automatic check_status();
		@(negedge clk_sys);
		check("status", status, exp_status);
		check("core_reset_n", 32'(core_reset_n),
			32'(!(exp_status[0] || exp_status[6] || buttons[1])));
	endtask

	task automatic send_pixels(input int n);
		int waited;
		waited = 0;
		req_count += n;
		while ((sent_count < req_count || sent_q.size() != 0) && waited < DRAIN_LIMIT) begin
			clocks(1);
			waited++;
		end
		if (sent_count < req_count || sent_q.size() != 0) begin
			$display("Timed out waiting for %0d pixels to reach the VGA port", n);
			errors++;
		end
	endtask

	task automatic report(input int num, input string name, input int errors_before);
		if (errors == errors_before)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - errors_before);
	endtask

	initial begin
		ce_pix = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			ce_phase = (ce_phase + 1) % 4;
			ce_pix   = (ce_phase == 0);
		end
	end

	// Core model that spends one credit per pushed pixel
	initial begin
		void'($urandom(32'hcc9c));
		pix_valid = 1'b0;
		pix_r     = 4'd0;
		pix_g     = 4'd0;
		pix_b     = 4'd0;
		pix_hs    = 1'b0;
		pix_vs    = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			if (credit_return) begin
				credits++;
				credits_back++;
			end
			pix_valid = 1'b0;
			if (arst_n && sent_count < req_count && credits > 0
					&& (!gap_en || $urandom_range(3) != 0)) begin
				pix_r     = 4'($urandom);
				pix_g     = 4'($urandom);
				pix_b     = 4'($urandom);
				pix_hs    = ($urandom_range(3) == 0);
				pix_vs    = ($urandom_range(31) == 0);
				pix_valid = 1'b1;
				sent_q.push_back({pix_r, pix_g, pix_b, pix_hs, pix_vs});
				credits--;
				sent_count++;
			end
		end
	end

	initial begin
		logic [13:0] p;
		logic        prev_hs;
		logic        prev_vs;
		logic        odd;
		prev_hs = 1'b0;
		prev_vs = 1'b0;
		odd     = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (ce_pix) begin
				@(negedge clk_sys);
				if (vga_de && sent_q.size() == 0) begin
					$display("vga_de was high with no pixel outstanding");
					errors++;
				end else if (vga_de) begin
					p = sent_q.pop_front();
					if (p[0] && !prev_vs)
						odd = 1'b0;
					else if (p[1] && !prev_hs)
						odd = ~odd; // Each hs rising edge starts a new line
					prev_hs = p[1];
					prev_vs = p[0];
					check("vga_r", 32'(vga_r), 32'(expect_color(p[13:10], exp_mode, odd)));
					check("vga_g", 32'(vga_g), 32'(expect_color(p[9:6], exp_mode, odd)));
					check("vga_b", 32'(vga_b), 32'(expect_color(p[5:2], exp_mode, odd)));
					check("vga_hs", 32'(vga_hs), 32'(p[1]));
					check("vga_vs", 32'(vga_vs), 32'(p[0]));
					shown++;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with %0d pixels outstanding", WATCHDOG_NS,
			sent_q.size());
		$display("Test failed");
		$finish;
	end

	initial begin
		int e0;
		int back0;
		int shown0;
		spi_sck  = 1'b0;
		spi_ss_n = 1'b1;
		spi_di   = 1'b0;
		buttons  = 2'b00;
		@(posedge arst_n);
		clocks(2);

		e0 = errors;
		@(negedge clk_sys);
		check("vga_de", 32'(vga_de), 32'd0);
		check("credit_return", 32'(credit_return), 32'd0);
		check("underflow", 32'(underflow), 32'd0);
		check("core_reset_n", 32'(core_reset_n), 32'd1);
		check("vga_r", 32'(vga_r), 32'd0);
		check("vga_g", 32'(vga_g), 32'd0);
		check("vga_b", 32'(vga_b), 32'd0);
		report(1, "reset values", e0);

		e0 = errors;
		send_pixels(N_PIX);
		report(2, "pass-through with mode none", e0);

		e0 = errors;
		status_frame(`STATUS_CMD, 32'h0000_0018, 4);
		check_status();
		send_pixels(N_PIX);
		status_frame(`STATUS_CMD, 32'h0000_0010, 4);
		check_status();
		send_pixels(N_PIX);
		report(3, "scanline dimming", e0);

		e0 = errors;
		status_frame(`STATUS_CMD, 32'h0000_0040, 4);
		check_status();
		status_frame(`STATUS_CMD, 32'h0000_0000, 2); // Short frame is dropped
		check_status();
		status_frame(`STATUS_CMD, 32'h0000_0000, 4);
		check_status();
		buttons = 2'b10;
		check_status();
		buttons = 2'b00;
		check_status();
		report(4, "core reset control", e0);

		e0     = errors;
		back0  = credits_back;
		shown0 = shown;
		gap_en = 1'b0;
		send_pixels(DEPTH);
		check("pixels shown", 32'(shown - shown0), 32'(DEPTH));
		check("credits returned", 32'(credits_back - back0), 32'(shown - shown0));
		check("credits held", 32'(credits), 32'(DEPTH));
		report(5, "credit flow", e0);

		e0 = errors;
		clocks(16);
		@(negedge clk_sys);
		check("underflow", 32'(underflow), 32'd1);
		check("vga_de", 32'(vga_de), 32'd0);
		check("vga_r", 32'(vga_r), 32'd0);
		check("vga_g", 32'(vga_g), 32'd0);
		check("vga_b", 32'(vga_b), 32'd0);
		report(6, "underflow", e0);

		$display("6 tests, %0d checks, %0d errors, %0d pixels shown", checks, errors, shown);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+logic
logic/video_pkg.sv
logic/ctrl_pkg.sv
logic/status_spi_rx.sv
logic/pixel_ingress.sv
logic/scanline_mixer.sv
logic/vga_egress.sv
logic/video_mist_top.sv
verif/tb_clock_gen.sv
verif/video_mist_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module video_mist_tb \
	--Mdir obj_dir \
	-o video_mist_sim

./obj_dir/video_mist_sim | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation passed"
